// File: hw/ppc_bus_pkg.sv
// ppc bus package with the shared widths, bus structs and state encodings of the split bus
package ppc_bus_pkg;

	// the alternating address arbiter is only defined for two masters
	localparam int NUM_MASTERS = 2;

	// widths that carry a meaning on the bus
	typedef logic [0:0] master_id_t;
	typedef logic [15:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	typedef enum logic {
		XFER_READ  = 1'b0,
		XFER_WRITE = 1'b1
	} xfer_kind_t;

	// one command as handed to a master from outside
	typedef struct packed {
		xfer_kind_t kind;
		bus_addr_t  addr;
		bus_data_t  wdata;
	} bus_cmd_t;

	// address bus contribution of one master, zero unless it drives a transfer start
	typedef struct packed {
		logic       ts;
		xfer_kind_t kind;
		bus_addr_t  addr;
	} addr_bus_t;

	// data bus contribution of one master, dbb is high while it holds the data bus
	typedef struct packed {
		logic      dbb;
		bus_data_t wdata;
	} data_bus_t;

	// IDLE1 and IDLE2 also remember who owned the address bus last
	typedef enum logic [2:0] {
		IDLE1, IDLE2, GRANTED1, GRANTED1_AACK, GRANTED2, GRANTED2_AACK
	} arb_state_t;

	typedef enum logic [2:0] {
		IDLE, REQUEST, START, ADDR_WAIT, RETRY_WINDOW, DATA_WAIT, DATA_TENURE
	} master_state_t;

endpackage

// File: hw/addr_arbiter.sv
// address bus arbiter that alternates under contention, parks the last owner and holds off on retry
`timescale 1ns/10ps

module addr_arbiter import ppc_bus_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [NUM_MASTERS-1:0] br_n,
	input  logic                   ts,
	input  logic                   aack_n,
	input  logic                   artry_n,
	output logic [NUM_MASTERS-1:0] bg_n
);

	arb_state_t state;

	// a request from each master, active high
	logic req0;
	logic req1;

	assign req0 = !br_n[0];
	assign req1 = !br_n[1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// after reset master 0 counts as the last owner
			state <= IDLE1;
		end else begin
			case (state)
				IDLE1, IDLE2: begin
					if (!artry_n) begin
						// no grant inside the retry window, the snooper
						// needs the bus free for its own request
						state <= state;
					end else if (ts) begin
						// a start without a fresh grant means the parked
						// owner used the bus, so track it as granted until
						// its acknowledge comes back
						state <= (state == IDLE1) ? GRANTED1 : GRANTED2;
					end else if (req0 && !req1) begin
						state <= GRANTED1;
					end else if (req1 && !req0) begin
						state <= GRANTED2;
					end else if (!req0 && !req1) begin
						state <= state;
					end else begin
						// both are asking, the one that did not own the
						// bus last gets it
						state <= (state == IDLE1) ? GRANTED2 : GRANTED1;
					end
				end
				GRANTED1: begin
					if (!aack_n)
						state <= GRANTED1_AACK;
				end
				// the grant stays out during the retry window cycle
				GRANTED1_AACK: begin
					state <= IDLE1;
				end
				GRANTED2: begin
					if (!aack_n)
						state <= GRANTED2_AACK;
				end
				GRANTED2_AACK: begin
					state <= IDLE2;
				end
				default: begin
					state <= IDLE1;
				end
			endcase
		end
	end

	// grants are pure decodes of the registered state
	assign bg_n[0] = !(state == GRANTED1 || state == GRANTED1_AACK);
	assign bg_n[1] = !(state == GRANTED2 || state == GRANTED2_AACK);

endmodule

// File: hw/data_arbiter.sv
// data bus arbiter granting masters in the order their address tenures completed
`timescale 1ns/10ps

module data_arbiter import ppc_bus_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   addr_done,
	input  master_id_t             addr_done_id,
	input  logic                   dbb_any,
	input  logic                   ta_n,
	output logic [NUM_MASTERS-1:0] dbg_n
);

	// two entries cover one finished address tenure per master
	master_id_t fifo [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] fifo_cnt;

	// active spans from the grant pulse until the transfer acknowledge
	logic       active;
	logic       dbg_valid;
	master_id_t dbg_id;

	logic pop;
	logic grant;

	assign pop   = !ta_n;
	assign grant = (fifo_cnt != 2'd0) && !active && !dbb_any;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= 1'b0;
			rd_ptr    <= 1'b0;
			fifo_cnt  <= 2'd0;
			active    <= 1'b0;
			dbg_valid <= 1'b0;
			dbg_id    <= '0;
		end else begin
			// the grant is a single cycle pulse
			dbg_valid <= 1'b0;
			if (grant) begin
				dbg_valid <= 1'b1;
				dbg_id    <= fifo[rd_ptr];
				active    <= 1'b1;
			end else if (pop) begin
				active <= 1'b0;
			end
			if (addr_done)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;
			case ({addr_done, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 2'd1;
				2'b01:   fifo_cnt <= fifo_cnt - 2'd1;
				default: fifo_cnt <= fifo_cnt;
			endcase
		end
	end

	// the id entries themselves need no reset
	always_ff @(posedge clk) begin
		if (addr_done)
			fifo[wr_ptr] <= addr_done_id;
	end

	always_comb begin
		for (int i = 0; i < NUM_MASTERS; i++)
			dbg_n[i] = !(dbg_valid && dbg_id == master_id_t'(i));
	end

endmodule

// File: hw/bus_master.sv
// bus master sequencing one command through its address tenure and its single-beat data tenure
`timescale 1ns/10ps

module bus_master import ppc_bus_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      cmd_strobe,
	input  bus_cmd_t  cmd,
	input  logic      bg_n,
	input  logic      aack_n,
	input  logic      artry_n,
	input  logic      dbg_n,
	input  logic      ta_n,
	input  bus_data_t read_data,
	output logic      br_n,
	output addr_bus_t abus,
	output data_bus_t dbus,
	output logic      addr_done,
	output logic      idle,
	output logic      done,
	output bus_data_t rdata
);

	master_state_t state;
	bus_cmd_t      cmd_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					// a strobe is only taken while idle
					if (cmd_strobe)
						state <= REQUEST;
				end
				REQUEST: begin
					// a grant seen here can only be ours, since no other
					// tenure of this master is open
					if (!bg_n)
						state <= START;
				end
				START: begin
					state <= ADDR_WAIT;
				end
				ADDR_WAIT: begin
					// only one address tenure runs at a time, so the
					// acknowledge in this state belongs to us
					if (!aack_n)
						state <= RETRY_WINDOW;
				end
				RETRY_WINDOW: begin
					// a retry sends us back to arbitrate again with the
					// same command
					if (!artry_n)
						state <= REQUEST;
					else
						state <= DATA_WAIT;
				end
				DATA_WAIT: begin
					if (!dbg_n)
						state <= DATA_TENURE;
				end
				DATA_TENURE: begin
					if (!ta_n) begin
						state <= IDLE;
						done  <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// command and returned data are payload registers
	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_strobe)
			cmd_q <= cmd;
		if (state == DATA_TENURE && !ta_n && cmd_q.kind == XFER_READ)
			rdata <= read_data;
	end

	// request is held from the cycle after acceptance until the start
	assign br_n = !(state == REQUEST);

	// the address bus is driven for the single start cycle only
	always_comb begin
		abus = '0;
		if (state == START) begin
			abus.ts   = 1'b1;
			abus.kind = cmd_q.kind;
			abus.addr = cmd_q.addr;
		end
	end

	// dbb and the write data stay up for the whole data tenure
	always_comb begin
		dbus = '0;
		if (state == DATA_TENURE) begin
			dbus.dbb   = 1'b1;
			dbus.wdata = cmd_q.wdata;
		end
	end

	// the address tenure is complete when the window passes without retry
	assign addr_done = (state == RETRY_WINDOW) && artry_n;
	assign idle      = (state == IDLE);

endmodule

// File: hw/bus_target.sv
// bus target answering address tenures with acknowledge or retry and serving single-beat data
`timescale 1ns/10ps

module bus_target import ppc_bus_pkg::*; #(
	parameter int ACK_LAT   = 2,
	parameter int DATA_LAT  = 3,
	parameter int MEM_WORDS = 64
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  addr_bus_t [NUM_MASTERS-1:0] abus,
	input  data_bus_t [NUM_MASTERS-1:0] dbus,
	input  logic                        snoop_hold,
	input  logic                        retry_ok,
	output logic                        aack_n,
	output logic                        artry_n,
	output logic                        ta_n,
	output bus_data_t                   read_data
);

	localparam int ACK_W = $clog2(ACK_LAT) + 1;
	localparam int DAT_W = $clog2(DATA_LAT) + 1;
	localparam int IDX_W = $clog2(MEM_WORDS);

	// only the bus owner drives non-zero values, so an OR merges the masters
	addr_bus_t abus_m;
	data_bus_t dbus_m;

	assign abus_m = abus[0] | abus[1];
	assign dbus_m = dbus[0] | dbus[1];

	// address tenure timing
	logic             a_busy;
	logic             a_window;
	logic [ACK_W-1:0] a_cnt;
	bus_addr_t        lat_addr;
	xfer_kind_t       lat_kind;
	logic             snooped;

	// data tenure timing
	logic             d_busy;
	logic [DAT_W-1:0] d_cnt;
	logic             ta;

	// acknowledged addresses waiting for their data tenure
	bus_addr_t  aq_addr [2];
	xfer_kind_t aq_kind [2];
	logic       aq_wr;
	logic       aq_rd;

	bus_data_t       mem [MEM_WORDS];
	logic [IDX_W-1:0] head_idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_busy   <= 1'b0;
			a_window <= 1'b0;
			a_cnt    <= '0;
			d_busy   <= 1'b0;
			d_cnt    <= '0;
			aq_wr    <= 1'b0;
			aq_rd    <= 1'b0;
		end else begin
			// the retry window is the one cycle after the acknowledge
			a_window <= 1'b0;
			if (a_busy) begin
				if (a_cnt == '0) begin
					a_busy   <= 1'b0;
					a_window <= 1'b1;
				end else begin
					a_cnt <= a_cnt - 1'b1;
				end
			end else if (abus_m.ts) begin
				a_busy <= 1'b1;
				a_cnt  <= ACK_W'(ACK_LAT - 1);
			end
			// dbb staying high through the acknowledge cycle is not a new start
			if (d_busy) begin
				if (d_cnt == '0)
					d_busy <= 1'b0;
				else
					d_cnt <= d_cnt - 1'b1;
			end else if (dbus_m.dbb) begin
				d_busy <= 1'b1;
				d_cnt  <= DAT_W'(DATA_LAT - 1);
			end
			if (retry_ok)
				aq_wr <= !aq_wr;
			if (ta)
				aq_rd <= !aq_rd;
		end
	end

	// payload side with the address latch, the queue entries and the memory
	always_ff @(posedge clk) begin
		if (abus_m.ts) begin
			lat_addr <= abus_m.addr;
			lat_kind <= abus_m.kind;
			// the snooper decision is taken at the start of the tenure
			snooped  <= snoop_hold;
		end
		if (retry_ok) begin
			aq_addr[aq_wr] <= lat_addr;
			aq_kind[aq_wr] <= lat_kind;
		end
		if (ta && aq_kind[aq_rd] == XFER_WRITE)
			mem[head_idx] <= dbus_m.wdata;
	end

	assign ta       = d_busy && (d_cnt == '0);
	assign head_idx = aq_addr[aq_rd][IDX_W-1:0];

	assign aack_n    = !(a_busy && a_cnt == '0);
	assign artry_n   = !(a_window && snooped);
	assign ta_n      = !ta;
	assign read_data = mem[head_idx];

endmodule

// File: hw/ppc_bus_subsys.sv
// two-master split bus subsystem with address and data arbiters and one memory target
`timescale 1ns/10ps

module ppc_bus_subsys import ppc_bus_pkg::*; #(
	parameter int ACK_LAT   = 2,
	parameter int DATA_LAT  = 3,
	parameter int MEM_WORDS = 64
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic      [NUM_MASTERS-1:0] cmd_strobe,
	input  bus_cmd_t  [NUM_MASTERS-1:0] cmd,
	input  logic                        snoop_hold,
	output logic      [NUM_MASTERS-1:0] idle,
	output logic      [NUM_MASTERS-1:0] done,
	output bus_data_t [NUM_MASTERS-1:0] rdata
);

	logic      [NUM_MASTERS-1:0] br_n;
	logic      [NUM_MASTERS-1:0] bg_n;
	logic      [NUM_MASTERS-1:0] dbg_n;
	logic      [NUM_MASTERS-1:0] addr_done;
	addr_bus_t [NUM_MASTERS-1:0] abus;
	data_bus_t [NUM_MASTERS-1:0] dbus;

	logic       aack_n;
	logic       artry_n;
	logic       ta_n;
	bus_data_t  read_data;
	logic       ts_any;
	logic       dbb_any;
	logic       addr_done_any;
	master_id_t addr_done_id;

	assign ts_any        = abus[0].ts | abus[1].ts;
	assign dbb_any       = dbus[0].dbb | dbus[1].dbb;
	assign addr_done_any = |addr_done;
	// at most one address tenure completes per cycle
	assign addr_done_id  = master_id_t'(addr_done[1]);

	addr_arbiter u_addr_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.br_n    (br_n),
		.ts      (ts_any),
		.aack_n  (aack_n),
		.artry_n (artry_n),
		.bg_n    (bg_n)
	);

	data_arbiter u_data_arb (
		.clk          (clk),
		.rst_n        (rst_n),
		.addr_done    (addr_done_any),
		.addr_done_id (addr_done_id),
		.dbb_any      (dbb_any),
		.ta_n         (ta_n),
		.dbg_n        (dbg_n)
	);

	for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
		bus_master u_master (
			.clk        (clk),
			.rst_n      (rst_n),
			.cmd_strobe (cmd_strobe[i]),
			.cmd        (cmd[i]),
			.bg_n       (bg_n[i]),
			.aack_n     (aack_n),
			.artry_n    (artry_n),
			.dbg_n      (dbg_n[i]),
			.ta_n       (ta_n),
			.read_data  (read_data),
			.br_n       (br_n[i]),
			.abus       (abus[i]),
			.dbus       (dbus[i]),
			.addr_done  (addr_done[i]),
			.idle       (idle[i]),
			.done       (done[i]),
			.rdata      (rdata[i])
		);
	end

	bus_target #(
		.ACK_LAT   (ACK_LAT),
		.DATA_LAT  (DATA_LAT),
		.MEM_WORDS (MEM_WORDS)
	) u_target (
		.clk        (clk),
		.rst_n      (rst_n),
		.abus       (abus),
		.dbus       (dbus),
		.snoop_hold (snoop_hold),
		.retry_ok   (addr_done_any),
		.aack_n     (aack_n),
		.artry_n    (artry_n),
		.ta_n       (ta_n),
		.read_data  (read_data)
	);

endmodule

// File: verif/ppc_bus_subsys_tb.sv
// testbench for the two-master split bus subsystem, driven by command vectors from a data file
`timescale 1ns/10ps

module ppc_bus_subsys_tb import ppc_bus_pkg::*; ();

	// any single wait longer than this counts as a hang
	localparam int TIMEOUT_CYCLES = 300;

	logic                        clk = 1'b0;
	logic                        rst_n;
	logic      [NUM_MASTERS-1:0] cmd_strobe;
	bus_cmd_t  [NUM_MASTERS-1:0] cmd;
	logic                        snoop_hold;
	logic      [NUM_MASTERS-1:0] idle;
	logic      [NUM_MASTERS-1:0] done;
	bus_data_t [NUM_MASTERS-1:0] rdata;

	// fields of the vector group being run
	int        valid [NUM_MASTERS];
	int        kind [NUM_MASTERS];
	bus_addr_t addr [NUM_MASTERS];
	bus_data_t wdata [NUM_MASTERS];
	bus_data_t exp_rdata [NUM_MASTERS];
	int        hold_cycles;
	int        exp_first;

	always #5 clk = ~clk;

	ppc_bus_subsys #(
		.ACK_LAT   (2),
		.DATA_LAT  (3),
		.MEM_WORDS (64)
	) dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_strobe (cmd_strobe),
		.cmd        (cmd),
		.snoop_hold (snoop_hold),
		.idle       (idle),
		.done       (done),
		.rdata      (rdata)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// both masters must be free before a new group is strobed in
	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (idle != 2'b11) begin
			if (cycles == TIMEOUT_CYCLES)
				abort_run("timeout while waiting for both masters to become idle");
			cycles++;
			@(negedge clk);
		end
	endtask

	// strobes one group, holds the snooper and then collects every done in order
	task automatic run_group();
		logic [NUM_MASTERS-1:0] pending;
		int                     first;
		int                     cycles;
		first   = -1;
		pending = '0;
		wait_idle();
		for (int i = 0; i < NUM_MASTERS; i++) begin
			cmd_strobe[i] = (valid[i] != 0);
			cmd[i].kind   = (kind[i] != 0) ? XFER_WRITE : XFER_READ;
			cmd[i].addr   = addr[i];
			cmd[i].wdata  = wdata[i];
			pending[i]    = (valid[i] != 0);
		end
		snoop_hold = (hold_cycles != 0);
		@(negedge clk);
		cmd_strobe = '0;
		// every start seen while the snooper holds is retried, so nothing may finish
		for (int k = 0; k < hold_cycles; k++) begin
			check_value("done", 32'(done), 32'h0);
			@(negedge clk);
		end
		snoop_hold = 1'b0;
		cycles = 0;
		while (pending != '0) begin
			for (int i = 0; i < NUM_MASTERS; i++) begin
				if (done[i]) begin
					if (!pending[i])
						abort_run($sformatf("master %0d signalled done without a command", i));
					if (first < 0)
						first = i;
					// read data is only meaningful together with done
					if (kind[i] == 0)
						check_value($sformatf("rdata[%0d]", i), rdata[i], exp_rdata[i]);
					pending[i] = 1'b0;
				end
			end
			if (pending != '0) begin
				if (cycles == TIMEOUT_CYCLES)
					abort_run($sformatf("timeout while waiting for done, pending mask %b", pending));
				cycles++;
				@(negedge clk);
			end
		end
		// data tenures run in address tenure order, so the first done shows who won the bus
		check_value("first_done", 32'(first), 32'(exp_first));
	endtask

	initial begin
		int               fd;
		int               n;
		int               gap;
		int               group;
		logic [8*160-1:0] line_buf;

		cmd_strobe = '0;
		cmd        = '0;
		snoop_hold = 1'b0;
		rst_n      = 1'b0;
		group      = 0;
		// seed the generator once, it only picks the idle gaps between groups
		gap = $urandom(32'hf20);

		// outputs must show the reset state on every cycle of reset
		repeat (8) begin
			@(negedge clk);
			check_value("idle", 32'(idle), 32'h3);
			check_value("done", 32'(done), 32'h0);
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_value("idle", 32'(idle), 32'h3);
		check_value("done", 32'(done), 32'h0);

		fd = $fopen("verif/ppc_bus_input.txt", "r");
		if (fd == 0)
			abort_run("cannot open the vector file verif/ppc_bus_input.txt");
		while (!$feof(fd)) begin
			line_buf = '0;
			if ($fgets(line_buf, fd) != 0) begin
				// comment and blank lines match no field and are skipped
				n = $sscanf(line_buf, "%d %d %h %h %d %d %h %h %d %h %h %d",
					valid[0], kind[0], addr[0], wdata[0],
					valid[1], kind[1], addr[1], wdata[1],
					hold_cycles, exp_rdata[0], exp_rdata[1], exp_first);
				if (n == 12) begin
					group++;
					run_group();
					gap = $urandom % 4;
					repeat (gap) @(negedge clk);
				end else if (n > 0) begin
					abort_run($sformatf("malformed vector line after group %0d", group));
				end
			end
		end
		$fclose(fd);
		if (group == 0)
			abort_run("the vector file holds no command groups");

		$display("All tests passed!");
		$finish;
	end

endmodule

// File: verif/ppc_bus_input.txt
# v0 kind0 addr0 wdata0 v1 kind1 addr1 wdata1 hold exp_rdata0 exp_rdata1 first
# kind 0 is read and 1 is write, addr and data in hex, hold cycles and first master in decimal
1 1 0010 deadbeef 0 0 0000 00000000 0 00000000 00000000 0
1 0 0010 00000000 0 0 0000 00000000 0 deadbeef 00000000 0
0 0 0000 00000000 1 1 0020 12345678 0 00000000 00000000 1
1 1 0030 cafef00d 0 0 0000 00000000 0 00000000 00000000 0
1 0 0020 00000000 1 0 0030 00000000 0 12345678 cafef00d 1
1 1 0004 0a0a0a0a 1 1 0008 0b0b0b0b 0 00000000 00000000 1
1 0 0008 00000000 1 0 0004 00000000 0 0b0b0b0b 0a0a0a0a 1
0 0 0000 00000000 1 0 0004 00000000 0 00000000 0a0a0a0a 1
1 0 0010 00000000 1 0 0020 00000000 0 deadbeef 12345678 0
1 1 0014 55aa55aa 0 0 0000 00000000 12 00000000 00000000 0
0 0 0000 00000000 1 0 0014 00000000 0 00000000 55aa55aa 1
0 0 0000 00000000 1 0 0030 00000000 20 00000000 cafef00d 1
1 1 0022 11112222 0 0 0000 00000000 0 00000000 00000000 0
1 1 0023 33334444 0 0 0000 00000000 0 00000000 00000000 0
1 0 0022 00000000 0 0 0000 00000000 0 11112222 00000000 0
1 0 0023 00000000 0 0 0000 00000000 0 33334444 00000000 0
0 0 0000 00000000 1 1 003f ffff0000 5 00000000 00000000 1
1 0 003f 00000000 1 0 0014 00000000 0 ffff0000 55aa55aa 0
1 1 0001 0badc0de 1 0 0022 00000000 0 00000000 11112222 0
0 0 0000 00000000 1 0 0001 00000000 0 00000000 0badc0de 1
1 0 0004 00000000 0 0 0000 00000000 3 0a0a0a0a 00000000 0

// File: ppc_bus_subsys.f
hw/ppc_bus_pkg.sv
hw/addr_arbiter.sv
hw/data_arbiter.sv
hw/bus_master.sv
hw/bus_target.sv
hw/ppc_bus_subsys.sv
verif/ppc_bus_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the split bus testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	-f ppc_bus_subsys.f \
	--top-module ppc_bus_subsys_tb \
	-Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q 'All tests passed!'; then
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi
